// ==== tests/shoot_cases.txt ====
# mode (0 solo, 1 multi, 2 multi with broken confirm), click x, click y,
# enemy verdict, expected is_scored; all decimal
0 112 150 0 1
0 912 150 0 1
0 112 600 0 1
0 912 600 0 1
0 111 300 0 0
0 913 300 0 0
0 500 149 0 0
0 500 601 0 0
0 400 250 0 0
0 600 550 0 0
0 399 250 0 1
0 601 550 0 1
0 500 249 0 1
0 500 551 0 1
0 50 50 0 0
0 800 400 0 1
1 345 678 1 0
1 1023 5 0 0
2 200 300 1 0
1 682 341 0 0
2 777 222 0 0

// ==== compile.f ====
hdl/shoot_pkg.sv
hdl/shoot_round_fsm.sv
hdl/shot_pos_tx.sv
hdl/shoot_control.sv
tests/shoot_control_props.sv
tests/shoot_control_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the shoot_control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f compile.f \
    --top-module shoot_control_tb \
    -o shoot_control_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/shoot_control_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
    exit 0
fi
echo "pass message not found"
exit 1

// ==== tests/shoot_control_tb.sv ====
/*
 * testbench for shoot_control
 * reads rounds from shoot_cases.txt, checks solo and multi verdicts,
 * round pulses, the four shot position words and back-pressure
 */

`timescale 1ns/1ps

module shoot_control_tb
    import shoot_pkg::*;
();

    localparam int HOLD_CYCLES    = 16;
    localparam int CONFIRM_CYCLES = 10;
    localparam int CLK_PERIOD     = 4;
    localparam int DRIVE_DELAY    = 1;
    localparam int RESET_CYCLES   = 5;
    localparam int LCG_SEED       = 60;
    localparam int CASE_CYCLES    = 2 * HOLD_CYCLES + 300; // longest multi round plus slack
    localparam int SOLO_WAIT      = HOLD_CYCLES + 20;
    localparam int END_WAIT       = 2 * (HOLD_CYCLES + 1) + CONFIRM_CYCLES + 20;
    localparam int BP_CYCLES      = 30;
    localparam int INTERRUPTS     = 6;

    // goal geometry as plain integers
    localparam int MOUTH_L = int'(POST_INNER_EDGE);
    localparam int MOUTH_R = int'(SCREEN_WIDTH) - int'(POST_INNER_EDGE);
    localparam int MOUTH_T = int'(CROSSBAR_BOTTOM_EDGE);
    localparam int MOUTH_B = int'(POST_BOTTOM_EDGE);
    localparam int KEEP_L  = int'(GK_LEFT);
    localparam int KEEP_R  = int'(GK_RIGHT);
    localparam int KEEP_T  = int'(GK_TOP);
    localparam int KEEP_B  = int'(GK_BOTTOM);

    localparam uart_op_t OP_ORDER [4] = '{OP_X_LO, OP_X_HI, OP_Y_LO, OP_Y_HI};

    logic             clk;
    logic             rst;
    game_state_t      game_state;
    game_mode_t       game_mode;
    logic [POS_W-1:0] xpos;
    logic [POS_W-1:0] ypos;
    logic             left_clicked;
    logic             tx_full;
    uart_op_t         rx_opcode;
    logic             enemy_done;
    logic             enemy_is_scored;
    logic             is_scored;
    logic             round_done;
    logic             end_sh;
    logic             shot_taken;
    logic [7:0]       tx_data;

    int          value_errs;
    int          timeout_errs;
    int          other_errs;
    int          tx_idx;   // expected word index
    int unsigned lcg_state;
    int          watchdog_cycles;
    logic        cases_ready;

    int case_mode[$];
    int case_x[$];
    int case_y[$];
    int case_enemy[$];
    int case_scored[$];

    shoot_control #(
        .HOLD_CYCLES    (HOLD_CYCLES),
        .CONFIRM_CYCLES (CONFIRM_CYCLES)
    ) UUT (
        .clk             (clk),
        .rst             (rst),
        .game_state      (game_state),
        .game_mode       (game_mode),
        .xpos            (xpos),
        .ypos            (ypos),
        .left_clicked    (left_clicked),
        .tx_full         (tx_full),
        .rx_opcode       (rx_opcode),
        .enemy_done      (enemy_done),
        .enemy_is_scored (enemy_is_scored),
        .is_scored       (is_scored),
        .round_done      (round_done),
        .end_sh          (end_sh),
        .shot_taken      (shot_taken),
        .tx_data         (tx_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %0h got %0h at %0t", name, exp, act, $time);
            value_errs++;
        end
    endtask

    task automatic check_word(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %02h got %02h at %0t", name, exp, act, $time);
            value_errs++;
        end
    endtask

    task automatic check_state(input string name, input uart_op_t exp, input uart_op_t act);
        if (act !== exp) begin
            $display("ERR %s expected %0h got %0h at %0t", name, exp, act, $time);
            value_errs++;
        end
    endtask

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // inside the mouth and outside the keeper box with inclusive edges
    function automatic logic goal_expected(input int x, input int y);
        logic in_mouth;
        logic in_keeper;
        in_mouth  = (x >= MOUTH_L) && (x <= MOUTH_R) && (y >= MOUTH_T) && (y <= MOUTH_B);
        in_keeper = (x >= KEEP_L) && (x <= KEEP_R) && (y >= KEEP_T) && (y <= KEEP_B);
        return in_mouth && !in_keeper;
    endfunction

    function automatic logic [7:0] expected_word(input int idx, input logic [SHOT_W-1:0] sx,
                                                 input logic [SHOT_W-1:0] sy);
        logic [4:0] payload;
        case (idx)
            0:       payload = sx[4:0];
            1:       payload = sx[9:5];
            2:       payload = sy[4:0];
            default: payload = sy[9:5];
        endcase
        return {payload, 3'(OP_ORDER[idx])};
    endfunction

    task automatic load_cases();
        int    fd;
        string line;
        int    m, x, y, e, s;
        fd = $fopen("tests/shoot_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/shoot_cases.txt");
            other_errs++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            if ($sscanf(line, "%d %d %d %d %d", m, x, y, e, s) == 5) begin
                case_mode.push_back(m);
                case_x.push_back(x);
                case_y.push_back(y);
                case_enemy.push_back(e);
                case_scored.push_back(s);
            end
        end
        $fclose(fd);
    endtask

    task automatic start_round(input game_mode_t mode, input int x, input int y);
        game_mode  = mode;
        game_state = SHOOTER;
        xpos       = POS_W'(x);
        ypos       = POS_W'(y);
        repeat (3) step(); // idle, engage, aim
        left_clicked = 1'b1;
        step();
        left_clicked = 1'b0;
    endtask

    // full period and an acknowledged drop put the word out two edges later
    task automatic send_word(input logic [SHOT_W-1:0] sx, input logic [SHOT_W-1:0] sy);
        tx_full = 1'b1;
        repeat (2) step();
        tx_full   = 1'b0;
        rx_opcode = OP_ROUND_END;
        step();
        rx_opcode = OP_X_LO;
        step();
        check_word("tx_data", expected_word(tx_idx, sx, sy), tx_data);
        check_state("tx_data opcode", OP_ORDER[tx_idx], uart_op_t'(tx_data[2:0]));
        tx_idx = (tx_idx + 1) % 4;
    endtask

    task automatic hold_backpressure(input logic [SHOT_W-1:0] sx, input logic [SHOT_W-1:0] sy);
        logic [7:0] held;
        held    = expected_word((tx_idx + 3) % 4, sx, sy); // last word sent
        tx_full = 1'b1;
        repeat (BP_CYCLES) begin
            step();
            check_word("tx_data", held, tx_data);
        end
        tx_full = 1'b0;
        repeat (2) step();
        check_word("tx_data", expected_word(tx_idx, sx, sy), tx_data); // index holds without an ack
    endtask

    task automatic expect_pending();
        check_bit("shot_taken", 1'b1, shot_taken);
        check_bit("end_sh", 1'b0, end_sh);
    endtask

    task automatic interrupt_confirm();
        int gap;
        int len;
        for (int k = 0; k < INTERRUPTS; k++) begin
            gap        = 1 + int'(lcg_next() % 8);
            len        = 1 + int'(lcg_next() % CONFIRM_CYCLES); // short of the confirm count
            enemy_done = 1'b0;
            repeat (gap) begin
                step();
                expect_pending();
            end
            enemy_done = 1'b1;
            repeat (len) begin
                step();
                expect_pending();
            end
        end
        enemy_done = 1'b0;
        step();
        expect_pending();
    endtask

    task automatic run_solo(input int n);
        logic exp_goal;
        logic prev_scored;
        int   waited;
        exp_goal = goal_expected(case_x[n], case_y[n]);
        if ((case_scored[n] != 0) != exp_goal) begin
            $display("case %0d: file verdict disagrees with the goal geometry", n);
            other_errs++;
        end
        start_round(SOLO, case_x[n], case_y[n]);
        prev_scored = is_scored;
        waited      = 0;
        while (!round_done && waited < SOLO_WAIT) begin
            prev_scored = is_scored;
            step();
            waited++;
        end
        game_state = MENU;
        if (!round_done) begin
            $display("case %0d: round_done never came after the click", n);
            timeout_errs++;
            return;
        end
        check_bit("is_scored", exp_goal, prev_scored);
        waited = 0;
        while (!end_sh && waited < 4) begin
            step();
            waited++;
        end
        if (!end_sh) begin
            $display("case %0d: end_sh did not follow round_done", n);
            timeout_errs++;
        end
    endtask

    task automatic run_multi(input int n);
        logic [SHOT_W-1:0] sx;
        logic [SHOT_W-1:0] sy;
        int                waited;
        sx = SHOT_W'(case_x[n]);
        sy = SHOT_W'(case_y[n]);
        if (case_scored[n] != 0) begin
            $display("case %0d: file expects is_scored in a multi round", n);
            other_errs++;
        end
        enemy_is_scored = (case_enemy[n] != 0);
        start_round(MULTI, case_x[n], case_y[n]);
        waited = 0;
        while (!shot_taken && waited < 4) begin
            step();
            waited++;
        end
        game_state = MENU;
        if (!shot_taken) begin
            $display("case %0d: shot_taken never rose after the click", n);
            timeout_errs++;
            return;
        end
        for (int w = 0; w < 4; w++)
            send_word(sx, sy);
        hold_backpressure(sx, sy);
        check_bit("shot_taken", 1'b1, shot_taken); // still waiting on the opponent
        if (case_mode[n] == 2)
            interrupt_confirm();
        enemy_done = 1'b1;
        waited     = 0;
        while (!end_sh && waited < END_WAIT) begin
            step();
            waited++;
            check_bit("is_scored", 1'b0, is_scored);
            check_bit("round_done", 1'b0, round_done);
        end
        enemy_done = 1'b0;
        if (!end_sh) begin
            $display("case %0d: end_sh never came after the enemy verdict", n);
            timeout_errs++;
            return;
        end
        check_bit("shot_taken", 1'b0, shot_taken);
    endtask

    initial begin
        rst             = 1'b1;
        game_state      = MENU;
        game_mode       = SOLO;
        xpos            = '0;
        ypos            = '0;
        left_clicked    = 1'b0;
        tx_full         = 1'b0;
        rx_opcode       = OP_X_LO;
        enemy_done      = 1'b0;
        enemy_is_scored = 1'b0;
        value_errs      = 0;
        timeout_errs    = 0;
        other_errs      = 0;
        tx_idx          = 0;
        lcg_state       = LCG_SEED;
        cases_ready     = 1'b0;

        load_cases();
        watchdog_cycles = case_mode.size() * CASE_CYCLES + RESET_CYCLES + 100;
        cases_ready     = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        check_bit("is_scored", 1'b0, is_scored);
        check_bit("round_done", 1'b0, round_done);
        check_bit("end_sh", 1'b0, end_sh);
        check_bit("shot_taken", 1'b0, shot_taken);
        check_word("tx_data", 8'h00, tx_data);

        for (int n = 0; n < case_mode.size(); n++) begin
            if (case_mode[n] == 0)
                run_solo(n);
            else
                run_multi(n);
            step();
        end

        $display("summary: %0d cases, %0d value errors, %0d timeouts, %0d other errors",
                 case_mode.size(), value_errs, timeout_errs, other_errs);
        if (value_errs == 0 && timeout_errs == 0 && other_errs == 0 && case_mode.size() > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        wait (cases_ready === 1'b1);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired before all rounds finished");
        $display("tests failed");
        $finish;
    end

endmodule

// ==== tests/shoot_control_props.sv ====
/*
 * concurrent checks on the shoot_control outputs
 * bound into the top level
 */

`timescale 1ns/1ps

module shoot_control_props
    import shoot_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input game_mode_t game_mode,
    input logic       is_scored,
    input logic       round_done,
    input logic       end_sh,
    input logic       shot_taken,
    input logic [7:0] tx_data
);

    round_done_pulse: assert property (@(posedge clk) disable iff (rst)
        round_done |=> !round_done)
        else $error("round_done high for more than one cycle");

    end_sh_pulse: assert property (@(posedge clk) disable iff (rst)
        end_sh |=> !end_sh)
        else $error("end_sh high for more than one cycle");

    // the multi verdict belongs to the opponent
    no_round_done_multi: assert property (@(posedge clk) disable iff (rst)
        round_done |-> (game_mode == SOLO))
        else $error("round_done raised in a multi round");

    taken_xor_scored: assert property (@(posedge clk) disable iff (rst)
        !(shot_taken && is_scored))
        else $error("shot_taken and is_scored high together");

    reset_clears: assert property (@(posedge clk)
        rst |=> (!is_scored && !round_done && !end_sh && !shot_taken && tx_data == 8'h00))
        else $error("outputs not cleared by reset");

endmodule

bind shoot_control shoot_control_props u_props (
    .clk        (clk),
    .rst        (rst),
    .game_mode  (game_mode),
    .is_scored  (is_scored),
    .round_done (round_done),
    .end_sh     (end_sh),
    .shot_taken (shot_taken),
    .tx_data    (tx_data)
);

// ==== hdl/shoot_control.sv ====
/*
 * shooter side top level
 * round controller plus shot position transmitter
 */

`timescale 1ns/1ps

module shoot_control
    import shoot_pkg::*;
#(
    parameter int HOLD_CYCLES    = 16_250_000, // about 0.25 s
    parameter int CONFIRM_CYCLES = 10
) (
    input  logic             clk,
    input  logic             rst,
    input  game_state_t      game_state,
    input  game_mode_t       game_mode,
    input  logic [POS_W-1:0] xpos,
    input  logic [POS_W-1:0] ypos,
    input  logic             left_clicked,
    input  logic             tx_full,
    input  uart_op_t         rx_opcode,
    input  logic             enemy_done,      // opponent round-end flag
    input  logic             enemy_is_scored,
    output logic             is_scored,
    output logic             round_done,
    output logic             end_sh,
    output logic             shot_taken,
    output logic [7:0]       tx_data
);

    logic shot_latch; // one-cycle pulse on a multi click

    shoot_round_fsm #(
        .HOLD_CYCLES    (HOLD_CYCLES),
        .CONFIRM_CYCLES (CONFIRM_CYCLES)
    ) u_round (
        .clk             (clk),
        .rst             (rst),
        .game_state      (game_state),
        .game_mode       (game_mode),
        .xpos            (xpos),
        .ypos            (ypos),
        .left_clicked    (left_clicked),
        .enemy_done      (enemy_done),
        .enemy_is_scored (enemy_is_scored),
        .is_scored       (is_scored),
        .round_done      (round_done),
        .end_sh          (end_sh),
        .shot_taken      (shot_taken),
        .shot_latch      (shot_latch)
    );

    shot_pos_tx u_tx (
        .clk        (clk),
        .rst        (rst),
        .shot_latch (shot_latch),
        .xpos       (xpos),
        .ypos       (ypos),
        .tx_full    (tx_full),
        .rx_opcode  (rx_opcode),
        .tx_data    (tx_data)
    );

endmodule

// ==== hdl/shot_pos_tx.sv ====
/*
 * shot position transmitter
 * latches the click and sends it as four opcode-tagged uart words
 */

`timescale 1ns/1ps

module shot_pos_tx
    import shoot_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             shot_latch,
    input  logic [POS_W-1:0] xpos,
    input  logic [POS_W-1:0] ypos,
    input  logic             tx_full,
    input  uart_op_t         rx_opcode,
    output logic [7:0]       tx_data
);

    localparam int SLICE_W = 5;

    logic [SHOT_W-1:0] shot_x;
    logic [SHOT_W-1:0] shot_y;

    tx_state_t  tx_state;
    tx_state_t  tx_state_nxt;
    logic [1:0] word_idx;
    logic       ack;
    logic [7:0] word;

    // payload is taken only on the latch pulse
    always_ff @(posedge clk) begin
        if (shot_latch) begin
            shot_x <= xpos[SHOT_W-1:0];
            shot_y <= ypos[SHOT_W-1:0];
        end
    end

    always_comb begin
        case (word_idx)
            2'd0:    word = {shot_x[SLICE_W-1:0], OP_X_LO};
            2'd1:    word = {shot_x[2*SLICE_W-1:SLICE_W], OP_X_HI};
            2'd2:    word = {shot_y[SLICE_W-1:0], OP_Y_LO};
            default: word = {shot_y[2*SLICE_W-1:SLICE_W], OP_Y_HI};
        endcase
    end

    always_comb begin
        tx_state_nxt = tx_state;
        case (tx_state)
            TX_WAIT: begin
                if (tx_full)
                    tx_state_nxt = TX_READY;
            end
            TX_READY: begin
                if (!tx_full)
                    tx_state_nxt = TX_SEND;
            end
            default: tx_state_nxt = TX_WAIT; // send is a single cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_state <= TX_WAIT;
            word_idx <= 2'd0;
            ack      <= 1'b0;
            tx_data  <= 8'h00;
        end else begin
            tx_state <= tx_state_nxt;
            ack      <= !tx_full && (rx_opcode == OP_ROUND_END); // opponent got the word

            if (tx_state == TX_SEND) begin
                tx_data <= word;
                if (ack)
                    word_idx <= word_idx + 2'd1; // wraps 3 -> 0
            end
        end
    end

endmodule

// ==== hdl/shoot_round_fsm.sv ====
/*
 * shooter round controller for solo and multi rounds
 * solo hit test against goal mouth minus keeper box,
 * enemy verdict confirm and result hold timing
 */

`timescale 1ns/1ps

module shoot_round_fsm
    import shoot_pkg::*;
#(
    parameter int HOLD_CYCLES    = 16_250_000,
    parameter int CONFIRM_CYCLES = 10
) (
    input  logic             clk,
    input  logic             rst,
    input  game_state_t      game_state,
    input  game_mode_t       game_mode,
    input  logic [POS_W-1:0] xpos,
    input  logic [POS_W-1:0] ypos,
    input  logic             left_clicked,
    input  logic             enemy_done,
    input  logic             enemy_is_scored,
    output logic             is_scored,
    output logic             round_done,
    output logic             end_sh,
    output logic             shot_taken,
    output logic             shot_latch
);

    // one counter covers both the hold timer and the confirm count
    localparam int CNT_MAX = (HOLD_CYCLES > CONFIRM_CYCLES) ? HOLD_CYCLES : CONFIRM_CYCLES;
    localparam int CNT_W   = (CNT_MAX < 2) ? 1 : $clog2(CNT_MAX + 1);

    localparam logic [CNT_W-1:0] HOLD_LAST    = CNT_W'(HOLD_CYCLES);
    localparam logic [CNT_W-1:0] CONFIRM_LAST = CNT_W'(CONFIRM_CYCLES);

    localparam logic [POS_W-1:0] MOUTH_RIGHT = SCREEN_WIDTH - POST_INNER_EDGE;

    shoot_state_t     state;
    shoot_state_t     state_nxt;
    logic [CNT_W-1:0] counter;
    logic [CNT_W-1:0] counter_nxt;

    logic in_mouth;
    logic in_keeper;
    logic solo_hit;

    // inclusive on every edge
    assign in_mouth = (xpos >= POST_INNER_EDGE) && (xpos <= MOUTH_RIGHT) &&
                      (ypos >= CROSSBAR_BOTTOM_EDGE) && (ypos <= POST_BOTTOM_EDGE);

    assign in_keeper = (xpos >= GK_LEFT) && (xpos <= GK_RIGHT) &&
                       (ypos >= GK_TOP) && (ypos <= GK_BOTTOM);

    assign solo_hit = in_mouth && !in_keeper;

    always_comb begin
        state_nxt   = state;
        counter_nxt = counter;

        case (state)
            IDLE: begin
                counter_nxt = '0;
                if (game_state == SHOOTER)
                    state_nxt = ENGAGE;
            end

            ENGAGE: begin // shooter phase must still hold one cycle later
                if (game_state == SHOOTER)
                    state_nxt = AIM;
                else
                    state_nxt = IDLE;
            end

            AIM: begin
                if (left_clicked)
                    state_nxt = RESULT;
            end

            RESULT: begin
                if (game_mode == SOLO) begin
                    counter_nxt = '0;
                    state_nxt   = solo_hit ? GOAL : MISS;
                end else if (!enemy_done) begin
                    counter_nxt = '0; // flag dropped so the count restarts
                end else if (counter == CONFIRM_LAST) begin
                    counter_nxt = '0;
                    state_nxt   = enemy_is_scored ? GOAL : MISS;
                end else begin
                    counter_nxt = counter + 1'b1;
                end
            end

            GOAL, MISS: begin
                if (counter == HOLD_LAST) begin
                    counter_nxt = '0;
                    state_nxt   = TERMINATE;
                end else begin
                    counter_nxt = counter + 1'b1;
                end
            end

            TERMINATE: begin
                // multi waits out a second hold
                if (game_mode == SOLO || counter == HOLD_LAST) begin
                    counter_nxt = '0;
                    state_nxt   = IDLE;
                end else begin
                    counter_nxt = counter + 1'b1;
                end
            end

            default: begin
                counter_nxt = '0;
                state_nxt   = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            counter    <= '0;
            is_scored  <= 1'b0;
            round_done <= 1'b0;
            end_sh     <= 1'b0;
            shot_taken <= 1'b0;
            shot_latch <= 1'b0;
        end else begin
            state   <= state_nxt;
            counter <= counter_nxt;

            // outputs follow the next state so they line up with it
            is_scored  <= (game_mode == SOLO) && (state_nxt == GOAL);
            round_done <= (game_mode == SOLO) && (state_nxt == TERMINATE) &&
                          (state != TERMINATE);
            end_sh     <= (state == TERMINATE) && (state_nxt == IDLE);
            shot_taken <= (game_mode == MULTI) && (state_nxt == RESULT);
            shot_latch <= (game_mode == MULTI) && (state == AIM) && left_clicked;
        end
    end

endmodule

// ==== hdl/shoot_pkg.sv ====
/*
 * shared types and constants for the shooter side
 * game and round enums, uart opcodes, goal and keeper geometry
 */

package shoot_pkg;

    typedef enum logic [1:0] {
        MENU,
        SHOOTER,
        KEEPER,
        OVER
    } game_state_t;

    typedef enum logic {
        SOLO,
        MULTI
    } game_mode_t;

    typedef enum logic [2:0] {
        IDLE, ENGAGE, AIM, RESULT, GOAL, MISS, TERMINATE
    } shoot_state_t;

    typedef enum logic [1:0] {
        TX_WAIT, TX_READY, TX_SEND
    } tx_state_t;

    // low 3 bits of every uart word
    typedef enum logic [2:0] {
        OP_X_LO      = 3'd3,
        OP_X_HI      = 3'd4,
        OP_Y_LO      = 3'd5,
        OP_Y_HI      = 3'd6,
        OP_ROUND_END = 3'd7
    } uart_op_t;

    localparam int POS_W  = 12;
    localparam int SHOT_W = 10;

    localparam logic [POS_W-1:0] SCREEN_WIDTH         = 12'd1024;
    localparam logic [POS_W-1:0] POST_INNER_EDGE      = 12'd112;
    localparam logic [POS_W-1:0] CROSSBAR_BOTTOM_EDGE = 12'd150;
    localparam logic [POS_W-1:0] POST_BOTTOM_EDGE     = 12'd600;

    localparam logic [POS_W-1:0] GK_LEFT   = 12'd400; // keeper box
    localparam logic [POS_W-1:0] GK_RIGHT  = 12'd600;
    localparam logic [POS_W-1:0] GK_TOP    = 12'd250;
    localparam logic [POS_W-1:0] GK_BOTTOM = 12'd550;

endpackage
